// ==== hdl/vlane_settings.svh ====
// Vector lane group sizing
// Lane count, VRF geometry and the widths derived from them

`ifndef VLANE_SETTINGS_SVH
`define VLANE_SETTINGS_SVH

// Lanes in one sub-lane set
`define VLANE_NUM        8

`define VRF_DEPTH        512                          // Words per lane VRF
`define VRF_ADDR_W       ($clog2(`VRF_DEPTH))

// Most elements held by one lane
`define MAX_VL_PER_LANE  256
`define ROW_W            ($clog2(`MAX_VL_PER_LANE) + 1)  // Row counter reaching delay + rows
`define VL_W             ($clog2(`VLANE_NUM * `MAX_VL_PER_LANE) + 1)
`define DELAY_W          ($clog2(`MAX_VL_PER_LANE))   // Pipeline delay before first write
`define VMRF_ADDR_W      ($clog2(`MAX_VL_PER_LANE))

`define ALU_OPMODE_W     6
`define RPORT_SEL_W      3                            // Read port select fields

`endif

// ==== hdl/vlane_cmd_pkg.sv ====
// Command types for the sub-lane sequencer
// Instruction kinds, FSM states, element widths and the command struct

`include "vlane_settings.svh"

package vlane_cmd_pkg;

    typedef enum logic [2:0] {
        INST_NORMAL        = 3'd0,
        INST_STORE         = 3'd2,
        INST_INDEXED_STORE = 3'd3,
        INST_LOAD          = 3'd4,
        INST_INDEXED_LOAD  = 3'd5
    } vlane_inst_e;                                   // Codes 1 and 6 reserved

    typedef enum logic [1:0] {ST_IDLE, ST_NORMAL, ST_READ, ST_LOAD} seq_state_e;

    typedef enum logic [1:0] {
        EW_NONE = 2'd0,
        EW_BYTE = 2'd1,
        EW_HALF = 2'd2,
        EW_WORD = 2'd3
    } elem_width_e;

    typedef struct packed {
        logic [1:0]                  op2_sel;
        logic [`RPORT_SEL_W-1:0]     op3_sel;
        logic [31:0]                 x_data;          // Scalar operand
        logic [4:0]                  imm;
        logic [`ALU_OPMODE_W-1:0]    opmode;
        logic                        vector_mask;
        logic                        en_32bit_mul;
    } alu_ctrl_t;

    typedef struct packed {
        vlane_inst_e                      inst_type;
        logic [`VL_W-1:0]                 vl;
        elem_width_e                      vsew;       // Read element width
        elem_width_e                      wdata_width;
        logic [`DELAY_W-1:0]              inst_delay;
        logic [`VRF_ADDR_W-1:0]           waddr_start;
        logic [2:0][`VRF_ADDR_W-1:0]      raddr_start; // vs1, vs2, vs3
        logic [`RPORT_SEL_W-1:0]          store_data_sel;
        logic [`RPORT_SEL_W-1:0]          index_sel;
        alu_ctrl_t                        alu;
    } vlane_cmd_t;

endpackage

// ==== hdl/vrf_port_pkg.sv ====
// VRF port types
// Word addresses, byte enables and the read and write port bundles

`include "vlane_settings.svh"

package vrf_port_pkg;

    // One word address inside a lane VRF
    typedef logic [`VRF_ADDR_W-1:0] vrf_addr_t;

    // Byte enables of one 32-bit word, bit 0 is the low byte
    typedef logic [3:0] vrf_bwen_t;

    ////////////////////////////////////////////////////////////
    // Port bundles

    // Broadcast to every lane of the set
    typedef struct packed {
        vrf_addr_t waddr;
        vrf_bwen_t bwen;
    } vrf_wr_t;

    typedef struct packed {
        vrf_addr_t [2:0] raddr;                       // 0 vs1, 1 vs2, 2 vs3
    } vrf_rd_t;

endpackage

// ==== hdl/vrf_addr_counter.sv ====
// VRF address counter
// Steps through a vector one element at a time and bumps the word
// address once all elements packed in the current word are done

`include "vlane_settings.svh"

module vrf_addr_counter (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        load_i,
    input  vrf_port_pkg::vrf_addr_t     start_addr_i,
    input  logic                        step_i,
    input  vlane_cmd_pkg::elem_width_e  width_i,
    output vrf_port_pkg::vrf_addr_t     addr_o
);
    import vlane_cmd_pkg::*;
    import vrf_port_pkg::*;

    vrf_addr_t  addr_q;
    logic [1:0] sub_q;                                // Element within the word
    logic [1:0] sub_last;                             // Last element of a word

    always_comb begin
        case (width_i)
            EW_BYTE: sub_last = 2'd3;
            EW_HALF: sub_last = 2'd1;
            default: sub_last = 2'd0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_q <= '0;
            sub_q  <= '0;
        end else if (load_i) begin
            addr_q <= start_addr_i;
            sub_q  <= '0;
        end else if (step_i && width_i != EW_NONE) begin
            if (sub_q == sub_last) begin              // Word full so move to the next
                addr_q <= addr_q + vrf_addr_t'(1);
                sub_q  <= '0;
            end else begin
                sub_q <= sub_q + 2'd1;
            end
        end
    end

    assign addr_o = addr_q;

    // Sub-count never runs past the elements of one word
    a_sub_in_range: assert property (@(posedge clk_i) disable iff (!rst_i)
        step_i && !load_i |=> sub_q <= $past(sub_last));

endmodule

// ==== hdl/vrf_bwen_gen.sv ====
// Byte-enable generator for sub-word VRF writes
// Rotates a one-hot byte lane or a halfword pair while writes run

`include "vlane_settings.svh"

module vrf_bwen_gen (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        step_i,
    input  vlane_cmd_pkg::elem_width_e  width_i,
    output vrf_port_pkg::vrf_bwen_t     bwen_o
);
    import vlane_cmd_pkg::*;
    import vrf_port_pkg::*;

    vrf_bwen_t  rot4_q;                               // Byte phase, one-hot
    logic [1:0] rot2_q;                               // Halfword phase

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rot4_q <= 4'b0001;
            rot2_q <= 2'b01;
        end else if (step_i) begin
            rot4_q <= {rot4_q[2:0], rot4_q[3]};
            rot2_q <= {rot2_q[0], rot2_q[1]};
        end else begin
            rot4_q <= 4'b0001;                        // Idle, back to phase 0
            rot2_q <= 2'b01;
        end
    end

    always_comb begin
        bwen_o = '0;
        if (step_i) begin
            case (width_i)
                EW_BYTE: bwen_o = rot4_q;
                EW_HALF: bwen_o = {{2{rot2_q[1]}}, {2{rot2_q[0]}}};
                EW_WORD: bwen_o = 4'b1111;
                default: bwen_o = '0;
            endcase
        end
    end

    a_bwen_legal: assert property (@(posedge clk_i) disable iff (!rst_i)
        bwen_o inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                       4'b0011, 4'b1100, 4'b1111});

endmodule

// ==== hdl/lane_valid_gen.sv ====
// Per-lane read data valid mask
// Tracks the elements still to be read and flags the lanes that hold
// one in the current row

`include "vlane_settings.svh"

module lane_valid_gen (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    load_i,
    input  logic [`VL_W-1:0]        vl_i,
    input  logic                    step_i,
    output logic [`VLANE_NUM-1:0]   valid_o
);

    logic [`VL_W-1:0] rem_q;                          // Elements not yet read

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rem_q <= '0;
        end else if (load_i) begin
            rem_q <= vl_i;
        end else if (step_i) begin
            // One row per step, stop at zero
            if (rem_q >= `VL_W'(`VLANE_NUM))
                rem_q <= rem_q - `VL_W'(`VLANE_NUM);
            else
                rem_q <= '0;
        end
    end

    // Lane i holds an element while more than i remain
    always_comb begin
        for (int i = 0; i < `VLANE_NUM; i++) begin
            valid_o[i] = step_i && (rem_q > `VL_W'(i));
        end
    end

endmodule

// ==== hdl/sublane_sequencer.sv ====
// Sub-lane sequencer
// Registers a command on start and walks it through the normal, read or
// load mode, driving counter steps, VMRF writes and store strobes

`include "vlane_settings.svh"

module sublane_sequencer (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        start_i,
    input  vlane_cmd_pkg::vlane_cmd_t   cmd_i,
    input  logic                        load_valid_i,
    input  logic                        load_last_i,
    output logic                        ready_o,
    output vlane_cmd_pkg::vlane_cmd_t   cmd_o,
    output logic                        ctr_load_o,
    output logic                        rd_step_o,
    output logic                        wr_step_o,
    output vlane_cmd_pkg::elem_width_e  wr_width_o,
    output logic [`VMRF_ADDR_W-1:0]     vmrf_addr_o,
    output logic                        vmrf_wen_o,
    output logic                        store_data_valid_o,
    output logic                        store_index_valid_o,
    output logic                        write_data_sel_o,
    output logic [1:0]                  el_extractor_o,
    output logic                        ready_for_load_o
);
    import vlane_cmd_pkg::*;

    seq_state_e              state_q;
    seq_state_e              state_d;
    vlane_cmd_t              cmd_q;
    logic [`ROW_W-1:0]       rows_q;
    logic [`ROW_W-1:0]       rows_d;
    logic [`ROW_W-1:0]       row_cnt_q;
    logic [`VMRF_ADDR_W-1:0] vmrf_cnt_q;
    logic [`VL_W-1:0]        vl_round;
    logic                    load_valid_q;            // Load beat seen last cycle
    logic                    accept;
    logic                    wr_window;
    logic                    load_wr;
    logic                    read_kind;
    logic                    normal_end;
    logic                    read_end;

    ////////////////////////////////////////////////////////////
    // Decode

    assign accept = start_i && ready_o;

    // rows = ceil(vl / lanes)
    assign vl_round = cmd_i.vl + `VL_W'(`VLANE_NUM - 1);
    assign rows_d   = `ROW_W'(vl_round >> $clog2(`VLANE_NUM));

    assign read_kind = cmd_q.inst_type inside {INST_STORE, INST_INDEXED_STORE,
                                               INST_INDEXED_LOAD};

    assign normal_end = row_cnt_q == (`ROW_W'(cmd_q.inst_delay) + rows_q);
    // Reserved codes leave after a single cycle
    assign read_end   = !read_kind || rows_q == '0 || row_cnt_q == rows_q - `ROW_W'(1);

    assign wr_window = state_q == ST_NORMAL && row_cnt_q > `ROW_W'(cmd_q.inst_delay);
    assign load_wr   = state_q == ST_LOAD && load_valid_q && !load_last_i;

    ////////////////////////////////////////////////////////////
    // FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    case (cmd_i.inst_type)
                        INST_NORMAL: state_d = ST_NORMAL;
                        INST_LOAD:   state_d = ST_LOAD;
                        default:     state_d = ST_READ;   // Stores, indexed, reserved
                    endcase
                end
            end
            ST_NORMAL: if (normal_end) state_d = ST_IDLE;
            ST_READ:   if (read_end) state_d = ST_IDLE;
            ST_LOAD:   if (load_last_i) state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= ST_IDLE;
            ready_o <= 1'b1;
        end else begin
            state_q <= state_d;
            ready_o <= (state_d == ST_IDLE);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmd_q  <= cmd_i;
            rows_q <= rows_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Row and VMRF counters

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            row_cnt_q    <= '0;
            vmrf_cnt_q   <= '0;
            load_valid_q <= 1'b0;
        end else begin
            if (accept)
                row_cnt_q <= '0;
            else if (state_q == ST_NORMAL || state_q == ST_READ)
                row_cnt_q <= row_cnt_q + `ROW_W'(1);

            if (accept)
                vmrf_cnt_q <= '0;
            else if (wr_window)
                vmrf_cnt_q <= vmrf_cnt_q + `VMRF_ADDR_W'(1);

            load_valid_q <= state_q == ST_LOAD && load_valid_i && !load_last_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs

    assign cmd_o      = cmd_q;
    assign ctr_load_o = accept;
    assign rd_step_o  = state_q == ST_NORMAL || (state_q == ST_READ && read_kind);
    assign wr_step_o  = wr_window || load_wr;
    assign wr_width_o = (state_q == ST_LOAD) ? EW_WORD : cmd_q.wdata_width;

    assign vmrf_addr_o = vmrf_cnt_q;
    assign vmrf_wen_o  = wr_window;

    assign store_data_valid_o  = state_q == ST_READ &&
                                 cmd_q.inst_type inside {INST_STORE, INST_INDEXED_STORE};
    assign store_index_valid_o = state_q == ST_READ &&
                                 cmd_q.inst_type inside {INST_INDEXED_STORE, INST_INDEXED_LOAD};

    assign write_data_sel_o = state_q == ST_LOAD;     // Load data into the VRF
    assign el_extractor_o   = row_cnt_q[1:0];
    assign ready_for_load_o = load_wr;

    a_ready_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        ready_o == (state_q == ST_IDLE));

    a_wr_step_mode: assert property (@(posedge clk_i) disable iff (!rst_i)
        wr_step_o |-> state_q inside {ST_NORMAL, ST_LOAD});

endmodule

// ==== hdl/sublane_driver.sv ====
// Sub-lane driver top
// Sequencer plus the VRF address counters, byte-enable and lane valid
// generators for one lane group

`include "vlane_settings.svh"

module sublane_driver (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        start_i,
    input  vlane_cmd_pkg::vlane_cmd_t   cmd_i,
    input  logic                        load_valid_i,
    input  logic                        load_last_i,
    output logic                        ready_o,
    output vrf_port_pkg::vrf_wr_t       vrf_wr_o,
    output vrf_port_pkg::vrf_rd_t       vrf_rd_o,
    output logic [`VMRF_ADDR_W-1:0]     vmrf_addr_o,
    output logic                        vmrf_wen_o,
    output logic [`VLANE_NUM-1:0]       read_data_valid_o,
    output logic                        store_data_valid_o,
    output logic                        store_index_valid_o,
    output logic [`RPORT_SEL_W-1:0]     store_data_sel_o,
    output logic [`RPORT_SEL_W-1:0]     index_sel_o,
    output vlane_cmd_pkg::alu_ctrl_t    alu_o,
    output logic                        write_data_sel_o,
    output logic [1:0]                  el_extractor_o,
    output logic                        ready_for_load_o
);
    import vlane_cmd_pkg::*;
    import vrf_port_pkg::*;

    vlane_cmd_t      cmd_q;
    elem_width_e     wr_width;
    vrf_addr_t       waddr;
    vrf_addr_t [2:0] raddr;
    vrf_bwen_t       bwen;
    logic            ctr_load;
    logic            rd_step;
    logic            wr_step;

    sublane_sequencer u_sequencer (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i), .cmd_i(cmd_i),
        .load_valid_i(load_valid_i), .load_last_i(load_last_i),
        .ready_o(ready_o), .cmd_o(cmd_q), .ctr_load_o(ctr_load),
        .rd_step_o(rd_step), .wr_step_o(wr_step), .wr_width_o(wr_width),
        .vmrf_addr_o(vmrf_addr_o), .vmrf_wen_o(vmrf_wen_o),
        .store_data_valid_o(store_data_valid_o),
        .store_index_valid_o(store_index_valid_o),
        .write_data_sel_o(write_data_sel_o), .el_extractor_o(el_extractor_o),
        .ready_for_load_o(ready_for_load_o)
    );

    // Start addresses come straight from the command being accepted
    vrf_addr_counter u_waddr_cnt (
        .clk_i(clk_i), .rst_i(rst_i), .load_i(ctr_load), .start_addr_i(cmd_i.waddr_start),
        .step_i(wr_step), .width_i(wr_width), .addr_o(waddr)
    );

    for (genvar i = 0; i < 3; i++) begin : g_raddr
        vrf_addr_counter u_raddr_cnt (
            .clk_i(clk_i), .rst_i(rst_i), .load_i(ctr_load),
            .start_addr_i(cmd_i.raddr_start[i]), .step_i(rd_step),
            .width_i(cmd_q.vsew), .addr_o(raddr[i])
        );
    end

    vrf_bwen_gen u_bwen_gen (
        .clk_i(clk_i), .rst_i(rst_i), .step_i(wr_step), .width_i(wr_width), .bwen_o(bwen)
    );

    lane_valid_gen u_lane_valid (
        .clk_i(clk_i), .rst_i(rst_i), .load_i(ctr_load), .vl_i(cmd_i.vl),
        .step_i(rd_step), .valid_o(read_data_valid_o)
    );

    assign vrf_wr_o.waddr   = waddr;                  // Same address in every lane
    assign vrf_wr_o.bwen    = bwen;
    assign vrf_rd_o.raddr   = raddr;
    assign store_data_sel_o = cmd_q.store_data_sel;
    assign index_sel_o      = cmd_q.index_sel;
    assign alu_o            = cmd_q.alu;

endmodule

// ==== dv/tb_sublane_driver.sv ====
// Testbench for the sub-lane driver
// Directed normal, store, indexed, load and reserved commands, each checked
// cycle by cycle against a row model of the sequencer timing

`include "vlane_settings.svh"

module tb_sublane_driver;
    import vlane_cmd_pkg::*;
    import vrf_port_pkg::*;

    localparam int MAX_ROWS   = 32;
    localparam int MAX_DELAY  = 7;
    localparam int LOAD_BEATS = 40;
    // Four normal, three read, one load and two reserved commands with idle gaps
    localparam int CYCLE_LIMIT = 8 + 4 * (MAX_DELAY + MAX_ROWS + 6) + 3 * (MAX_ROWS + 4)
                               + (LOAD_BEATS + 4) + 2 * 4 + 100;

    logic                       clk_i = 1'b0;
    logic                       rst_i;
    logic                       start_i;
    vlane_cmd_t                 cmd_i;
    logic                       load_valid_i;
    logic                       load_last_i;
    logic                       ready_o;
    vrf_wr_t                    vrf_wr_o;
    vrf_rd_t                    vrf_rd_o;
    logic [`VMRF_ADDR_W-1:0]    vmrf_addr_o;
    logic                       vmrf_wen_o;
    logic [`VLANE_NUM-1:0]      read_data_valid_o;
    logic                       store_data_valid_o;
    logic                       store_index_valid_o;
    logic [`RPORT_SEL_W-1:0]    store_data_sel_o;
    logic [`RPORT_SEL_W-1:0]    index_sel_o;
    alu_ctrl_t                  alu_o;
    logic                       write_data_sel_o;
    logic [1:0]                 el_extractor_o;
    logic                       ready_for_load_o;

    logic [31:0] seed = 32'd74554;
    int          cycle_cnt = 0;

    sublane_driver u_sublane_driver (.*);

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles, the DUT appears hung", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {16'h0, seed[31:16]};                  // High bits have the longer period
    endfunction

    task automatic compare_val(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    function automatic int width_shift(input elem_width_e w);
        case (w)
            EW_BYTE: return 2;
            EW_HALF: return 1;
            default: return 0;
        endcase
    endfunction

    // Byte enables of the k-th write
    function automatic vrf_bwen_t bwen_expect(input elem_width_e w, input int k);
        case (w)
            EW_BYTE: return 4'b0001 << (k % 4);
            EW_HALF: return (k % 2) ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // Lanes still holding an element in the given row
    function automatic logic [`VLANE_NUM-1:0] lane_mask(input int vl, input int row);
        int rem;
        rem = vl - `VLANE_NUM * row;
        if (rem >= `VLANE_NUM)
            return '1;
        if (rem <= 0)
            return '0;
        return (1 << rem) - 1;
    endfunction

    function automatic vlane_cmd_t random_cmd(input vlane_inst_e inst, input elem_width_e w);
        vlane_cmd_t  c;
        logic [63:0] r;
        c             = '0;
        c.inst_type   = inst;
        c.vl          = next_rand() % 200 + 33;       // At least five rows
        c.vsew        = w;
        c.wdata_width = w;
        c.inst_delay  = next_rand() % (MAX_DELAY + 1);
        c.waddr_start = next_rand();
        for (int i = 0; i < 3; i++)
            c.raddr_start[i] = next_rand();
        c.store_data_sel = next_rand();
        c.index_sel      = next_rand();
        r     = {next_rand(), next_rand()};
        c.alu = r[$bits(alu_ctrl_t)-1:0];
        return c;
    endfunction

    task automatic issue_cmd(input vlane_cmd_t c);
        @(negedge clk_i);
        compare_val("ready_o", ready_o, 1);
        cmd_i   = c;
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        cmd_i   = '0;                                 // Command must come from the register
    endtask

    task automatic expect_ctrl(input vlane_cmd_t c);
        compare_val("ready_o", ready_o, 0);
        compare_val("alu_o", alu_o, c.alu);
        compare_val("store_data_sel_o", store_data_sel_o, c.store_data_sel);
        compare_val("index_sel_o", index_sel_o, c.index_sel);
    endtask

    task automatic expect_raddr(input vlane_cmd_t c, input int j);
        vrf_addr_t exp_addr;
        for (int i = 0; i < 3; i++) begin
            exp_addr = vrf_addr_t'(c.raddr_start[i] + (j >> width_shift(c.vsew)));
            compare_val($sformatf("vrf_rd_o.raddr[%0d]", i), vrf_rd_o.raddr[i], exp_addr);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests

    task automatic reset_state_test();
        compare_val("ready_o", ready_o, 1);
        compare_val("vrf_wr_o.bwen", vrf_wr_o.bwen, 0);
        compare_val("vmrf_wen_o", vmrf_wen_o, 0);
        compare_val("store_data_valid_o", store_data_valid_o, 0);
        compare_val("store_index_valid_o", store_index_valid_o, 0);
        compare_val("ready_for_load_o", ready_for_load_o, 0);
        compare_val("read_data_valid_o", read_data_valid_o, 0);
    endtask

    // Poke raises start_i mid-command, which must be ignored
    task automatic normal_cmd_test(input elem_width_e w, input logic poke);
        vlane_cmd_t c;
        int         rows;
        int         k;
        c    = random_cmd(INST_NORMAL, w);
        rows = (int'(c.vl) + 7) / 8;
        issue_cmd(c);
        for (int j = 0; j <= int'(c.inst_delay) + rows; j++) begin
            if (j > 0)
                @(negedge clk_i);
            start_i = poke && j == 1;
            if (poke && j == 1) begin
                cmd_i           = c;
                cmd_i.inst_type = INST_LOAD;
            end
            #1;
            expect_ctrl(c);
            expect_raddr(c, j);
            compare_val("el_extractor_o", el_extractor_o, j % 4);
            compare_val("read_data_valid_o", read_data_valid_o, lane_mask(c.vl, j));
            compare_val("store_data_valid_o", store_data_valid_o, 0);
            if (j > int'(c.inst_delay)) begin         // Write window
                k = j - int'(c.inst_delay) - 1;
                compare_val("vrf_wr_o.bwen", vrf_wr_o.bwen, bwen_expect(w, k));
                compare_val("vrf_wr_o.waddr", vrf_wr_o.waddr,
                            vrf_addr_t'(c.waddr_start + (k >> width_shift(w))));
                compare_val("vmrf_wen_o", vmrf_wen_o, 1);
                compare_val("vmrf_addr_o", vmrf_addr_o, k);
            end else begin
                compare_val("vrf_wr_o.bwen", vrf_wr_o.bwen, 0);
                compare_val("vmrf_wen_o", vmrf_wen_o, 0);
            end
        end
        @(negedge clk_i);
        start_i = 1'b0;
        #1;
        compare_val("ready_o", ready_o, 1);
        compare_val("vrf_wr_o.bwen", vrf_wr_o.bwen, 0);
        compare_val("vmrf_wen_o", vmrf_wen_o, 0);
        compare_val("write_data_sel_o", write_data_sel_o, 0);
    endtask

    task automatic read_cmd_test(input vlane_inst_e inst, input elem_width_e w);
        vlane_cmd_t c;
        int         rows;
        c = random_cmd(inst, w);
        if (c.vl % 8 == 0)
            c.vl = c.vl + 3;                          // Force a partial last row
        rows = (int'(c.vl) + 7) / 8;
        issue_cmd(c);
        for (int j = 0; j < rows; j++) begin
            if (j > 0)
                @(negedge clk_i);
            #1;
            expect_ctrl(c);
            expect_raddr(c, j);
            compare_val("el_extractor_o", el_extractor_o, j % 4);
            compare_val("read_data_valid_o", read_data_valid_o, lane_mask(c.vl, j));
            compare_val("store_data_valid_o", store_data_valid_o,
                        inst == INST_STORE || inst == INST_INDEXED_STORE);
            compare_val("store_index_valid_o", store_index_valid_o,
                        inst == INST_INDEXED_STORE || inst == INST_INDEXED_LOAD);
            compare_val("vrf_wr_o.bwen", vrf_wr_o.bwen, 0);
            compare_val("vmrf_wen_o", vmrf_wen_o, 0);
        end
        @(negedge clk_i);
        #1;
        compare_val("ready_o", ready_o, 1);
        compare_val("store_data_valid_o", store_data_valid_o, 0);
        compare_val("store_index_valid_o", store_index_valid_o, 0);
        compare_val("read_data_valid_o", read_data_valid_o, 0);
    endtask

    task automatic load_cmd_test();
        vlane_cmd_t  c;
        logic        prev_valid;
        logic [31:0] r;
        int          writes;
        c          = random_cmd(INST_LOAD, EW_BYTE);  // Load always writes full words
        prev_valid = 1'b0;
        writes     = 0;
        issue_cmd(c);
        for (int n = 0; n <= LOAD_BEATS; n++) begin
            if (n > 0)
                @(negedge clk_i);
            r            = next_rand();
            load_valid_i = r[15];
            load_last_i  = (n == LOAD_BEATS);
            #1;
            expect_ctrl(c);
            compare_val("write_data_sel_o", write_data_sel_o, 1);
            if (prev_valid && !load_last_i) begin
                compare_val("ready_for_load_o", ready_for_load_o, 1);
                compare_val("vrf_wr_o.bwen", vrf_wr_o.bwen, 4'b1111);
                compare_val("vrf_wr_o.waddr", vrf_wr_o.waddr,
                            vrf_addr_t'(c.waddr_start + writes));
                writes++;
            end else begin
                compare_val("ready_for_load_o", ready_for_load_o, 0);
                compare_val("vrf_wr_o.bwen", vrf_wr_o.bwen, 0);
            end
            prev_valid = load_valid_i;
        end
        @(negedge clk_i);
        load_valid_i = 1'b0;
        load_last_i  = 1'b0;
        #1;
        compare_val("ready_o", ready_o, 1);
        compare_val("write_data_sel_o", write_data_sel_o, 0);
        compare_val("ready_for_load_o", ready_for_load_o, 0);
    endtask

    task automatic reserved_code_test(input logic [2:0] code);
        vlane_cmd_t c;
        c           = random_cmd(INST_NORMAL, EW_WORD);
        c.inst_type = vlane_inst_e'(code);
        issue_cmd(c);
        #1;
        compare_val("ready_o", ready_o, 0);
        compare_val("vrf_wr_o.bwen", vrf_wr_o.bwen, 0);
        compare_val("vmrf_wen_o", vmrf_wen_o, 0);
        compare_val("store_data_valid_o", store_data_valid_o, 0);
        compare_val("store_index_valid_o", store_index_valid_o, 0);
        compare_val("read_data_valid_o", read_data_valid_o, 0);
        @(negedge clk_i);
        #1;
        compare_val("ready_o", ready_o, 1);
        compare_val("vrf_wr_o.bwen", vrf_wr_o.bwen, 0);
    endtask

    initial begin
        rst_i        = 1'b0;
        start_i      = 1'b0;
        cmd_i        = '0;
        load_valid_i = 1'b0;
        load_last_i  = 1'b0;
        repeat (8) @(negedge clk_i);
        rst_i = 1'b1;
        #1;
        reset_state_test();
        normal_cmd_test(EW_BYTE, 1'b0);
        normal_cmd_test(EW_HALF, 1'b0);
        normal_cmd_test(EW_WORD, 1'b0);
        normal_cmd_test(EW_HALF, 1'b1);
        read_cmd_test(INST_STORE, EW_BYTE);
        read_cmd_test(INST_INDEXED_STORE, EW_HALF);
        read_cmd_test(INST_INDEXED_LOAD, EW_WORD);
        load_cmd_test();
        reserved_code_test(3'd1);
        reserved_code_test(3'd6);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/vlane_cmd_pkg.sv
hdl/vrf_port_pkg.sv
hdl/vrf_addr_counter.sv
hdl/vrf_bwen_gen.sv
hdl/lane_valid_gen.sv
hdl/sublane_sequencer.sv
hdl/sublane_driver.sv
dv/tb_sublane_driver.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the sub-lane driver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_sublane_driver -Mdir obj_dir -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
